/* erx_pkg.sv */
//##########################################################################
// shared types of the receive path
// mesh packet width, the 104-bit mesh packet struct,
// and the arbiter priority enum
//##########################################################################

`default_nettype none

package erx_pkg;

   // width of one mesh packet on every internal bus
   localparam int packet_width = 104;

   //##########################################################################
   // mesh packet, msb first
   //##########################################################################
   typedef struct packed {
      logic [31:0] srcaddr;    // return address for reads
      logic [31:0] data;       // write data or read payload
      logic [31:0] dstaddr;    // target address
      logic [3:0]  ctrlmode;   // routing and special modes
      logic [1:0]  datamode;   // 8/16/32/64 bit access size
      logic        write;      // 1 = write, 0 = read request
      logic        access;     // transaction marker
   } emesh_packet_t;

   // queue that is served first when both hold packets
   typedef enum logic {
      sel_wr = 1'b0,           // write queue first
      sel_rd = 1'b1            // read queue first
   } arb_sel_e;

endpackage

`default_nettype wire

/* erx_framer.sv */
//##########################################################################
// receive framer
// one-hot word pointer with burst wrap, 112-bit sample register,
// access pulse and burst detection
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module erx_framer (
   input  wire          rx_lclk,        // link clock
   input  wire          erx_io_reset,   // async, active high
   input  wire  [15:0]  rx_word,        // one word per cycle from the samplers
   input  wire          rx_frame,       // frame level
   output logic [111:0] sample,         // seven gathered words
   output logic         sample_access,  // sample complete
   output logic         sample_burst    // this sample continues a burst
);

   logic [6:0] ptr;   // one-hot slot of the next word

   //##########################################################################
   // write pointer
   //##########################################################################
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         ptr <= 7'b0000001;
      else if (!rx_frame)
         ptr <= 7'b0000001;              // idle, wait for header word
      else if (ptr[6])
         ptr <= 7'b0001000;              // expect burst, keep words 0..2
      else
         ptr <= {ptr[5:0], 1'b0};        // next word of the frame
   end

   // word k lands in bits 16k+15..16k
   always_ff @(posedge rx_lclk)
   begin
      for (int k = 0; k < 7; k++)
      begin
         if (rx_frame && ptr[k])
            sample[16*k +: 16] <= rx_word;
      end
   end

   //##########################################################################
   // access and burst
   //##########################################################################
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         sample_access <= 1'b0;
      else
         sample_access <= ptr[6] & rx_frame;   // last word just stored
   end

   // frame still high in the access cycle means another packet follows
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         sample_burst <= 1'b0;
      else if (!rx_frame)
         sample_burst <= 1'b0;            // burst over
      else if (sample_access)
         sample_burst <= 1'b1;
   end

   // pointer must never lose or duplicate its token
   a_ptr_onehot : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      $onehot(ptr))
      else $error("framer pointer not one-hot: ptr=%h", ptr);

endmodule

`default_nettype wire

/* erx_unpack.sv */
//##########################################################################
// packet unpacker
// reorders the 112-bit sample into a mesh packet
// and steers it to the write or read queue
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module erx_unpack (
   input  wire                    rx_lclk,
   input  wire                    erx_io_reset,
   input  wire  [111:0]           sample,
   input  wire                    sample_access,
   input  wire                    sample_burst,
   output erx_pkg::emesh_packet_t pkt,        // registered packet
   output logic                   pkt_burst,  // burst flag of pkt
   output logic                   wr_push,    // pkt goes to write queue
   output logic                   rd_push     // pkt goes to read queue
);

   erx_pkg::emesh_packet_t pkt_next;   // field map of the current sample

   // byte shuffle from link order into packet fields
   always_comb
   begin
      pkt_next.access   = sample[40];
      pkt_next.write    = sample[41];
      pkt_next.datamode = sample[43:42];
      pkt_next.ctrlmode = sample[15:12];
      pkt_next.dstaddr  = {sample[11:8], sample[23:16], sample[31:24],
                           sample[39:32], sample[47:44]};
      pkt_next.data     = {sample[55:48], sample[63:56],
                           sample[71:64], sample[79:72]};
      pkt_next.srcaddr  = {sample[87:80], sample[95:88],
                           sample[103:96], sample[111:104]};
   end

   always_ff @(posedge rx_lclk)
   begin
      if (sample_access)
      begin
         pkt       <= pkt_next;
         pkt_burst <= sample_burst;     // burst lags one packet behind frame
      end
   end

   // steer by write bit so the push lines up with the new pkt
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
      begin
         wr_push <= 1'b0;
         rd_push <= 1'b0;
      end
      else
      begin
         wr_push <= sample_access &  pkt_next.write;
         rd_push <= sample_access & ~pkt_next.write;
      end
   end

   a_push_excl : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      !(wr_push && rd_push))
      else $error("both pushes high: wr_push=%b rd_push=%b", wr_push, rd_push);

endmodule

`default_nettype wire

/* erx_queue.sv */
//##########################################################################
// packet queue
// circular buffer of mesh packets with burst flags,
// occupancy count and nearly-full wait level
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module erx_queue #(
   parameter int queue_depth = 8          // power of two, 4 or more
) (
   input  wire                    rx_lclk,
   input  wire                    erx_io_reset,
   input  wire                    push,
   input  erx_pkg::emesh_packet_t push_pkt,
   input  wire                    push_burst,
   input  wire                    pop,
   output erx_pkg::emesh_packet_t head_pkt,    // oldest entry
   output logic                   head_burst,
   output logic                   not_empty,
   output logic                   q_wait       // nearly full, toward the link
);

   localparam int aw = $clog2(queue_depth);

   logic [erx_pkg::packet_width-1:0] pkt_mem [queue_depth];
   logic [queue_depth-1:0]           burst_mem;
   logic [aw-1:0]                    wr_ptr;    // next free slot
   logic [aw-1:0]                    rd_ptr;    // head slot
   logic [aw:0]                      count;     // occupancy, 0..queue_depth

   //##########################################################################
   // storage
   //##########################################################################
   always_ff @(posedge rx_lclk)
   begin
      if (push)
      begin
         pkt_mem[wr_ptr]   <= push_pkt;
         burst_mem[wr_ptr] <= push_burst;
      end
   end

   // pointers wrap on their own width
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;   // push with pop keeps count
      end
   end

   assign head_pkt   = erx_pkg::emesh_packet_t'(pkt_mem[rd_ptr]);
   assign head_burst = burst_mem[rd_ptr];
   assign not_empty  = (count != '0);
   assign q_wait     = (count >= queue_depth - 2);   // two slots of slack

   // link sender must honour wait, arbiter must check not_empty
   a_no_overflow : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      push |-> (count != queue_depth))
      else $error("push into full queue: count=%h", count);

   a_no_underflow : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      pop |-> (count != '0))
      else $error("pop from empty queue: count=%h", count);

endmodule

`default_nettype wire

/* erx_arbiter.sv */
//##########################################################################
// mesh output arbiter
// alternating priority between write and read queue,
// combinational pops and registered mesh outputs
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module erx_arbiter (
   input  wire                    rx_lclk,
   input  wire                    erx_io_reset,
   input  erx_pkg::emesh_packet_t wr_pkt,
   input  wire                    wr_burst,
   input  wire                    wr_not_empty,
   input  erx_pkg::emesh_packet_t rd_pkt,
   input  wire                    rd_burst,
   input  wire                    rd_not_empty,
   input  wire                    mesh_wait,     // mesh cannot take a packet
   output logic                   wr_pop,
   output logic                   rd_pop,
   output logic                   mesh_access,
   output erx_pkg::emesh_packet_t mesh_packet,
   output logic                   mesh_burst
);

   erx_pkg::arb_sel_e pri;   // class served first on a tie

   // grant, priority class wins only if the other one is also waiting
   always_comb
   begin
      wr_pop = 1'b0;
      rd_pop = 1'b0;
      if (!mesh_wait)
      begin
         if (wr_not_empty && (pri == erx_pkg::sel_wr || !rd_not_empty))
            wr_pop = 1'b1;
         else if (rd_not_empty)
            rd_pop = 1'b1;
      end
   end

   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
      begin
         pri         <= erx_pkg::sel_wr;
         mesh_access <= 1'b0;
      end
      else
      begin
         if (wr_pop)
            pri <= erx_pkg::sel_rd;     // other side next time
         else if (rd_pop)
            pri <= erx_pkg::sel_wr;
         mesh_access <= wr_pop | rd_pop;
      end
   end

   // payload only moves on a grant
   always_ff @(posedge rx_lclk)
   begin
      if (wr_pop)
      begin
         mesh_packet <= wr_pkt;
         mesh_burst  <= wr_burst;
      end
      else if (rd_pop)
      begin
         mesh_packet <= rd_pkt;
         mesh_burst  <= rd_burst;
      end
   end

   a_pop_excl : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      !(wr_pop && rd_pop))
      else $error("both pops high: wr_pop=%b rd_pop=%b", wr_pop, rd_pop);

   // a waiting read is never passed over twice
   a_alt_rd : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      (wr_pop && rd_not_empty) |=> !wr_pop)
      else $error("write served twice while read waits");

   a_alt_wr : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      (rd_pop && wr_not_empty) |=> !rd_pop)
      else $error("read served twice while write waits");

endmodule

`default_nettype wire

/* erx_top.sv */
//##########################################################################
// receive subsystem top
// framer, unpacker, write and read queues, mesh arbiter
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module erx_top #(
   parameter int queue_depth = 8          // entries per queue
) (
   input  wire                    rx_lclk,
   input  wire                    erx_io_reset,
   input  wire  [15:0]            rx_word,
   input  wire                    rx_frame,
   input  wire                    mesh_wait,
   output logic                   mesh_access,
   output erx_pkg::emesh_packet_t mesh_packet,
   output logic                   mesh_burst,
   output logic                   wr_wait,       // write queue nearly full
   output logic                   rd_wait        // read queue nearly full
);

   logic [111:0]           sample;
   logic                   sample_access;
   logic                   sample_burst;
   erx_pkg::emesh_packet_t pkt;
   logic                   pkt_burst;
   logic                   wr_push, rd_push;
   erx_pkg::emesh_packet_t wr_head, rd_head;
   logic                   wr_head_burst, rd_head_burst;
   logic                   wr_not_empty, rd_not_empty;
   logic                   wr_pop, rd_pop;

   // struct layout must match the mesh bus width
   if ($bits(erx_pkg::emesh_packet_t) != erx_pkg::packet_width)
   begin : g_width_check
      $error("emesh_packet_t is %0d bits", $bits(erx_pkg::emesh_packet_t));
   end

   erx_framer u_framer (.rx_lclk, .erx_io_reset, .rx_word, .rx_frame,
                        .sample, .sample_access, .sample_burst);

   erx_unpack u_unpack (.rx_lclk, .erx_io_reset, .sample, .sample_access,
                        .sample_burst, .pkt, .pkt_burst, .wr_push, .rd_push);

   erx_queue #(.queue_depth(queue_depth)) wr_q (
      .rx_lclk, .erx_io_reset, .push(wr_push), .push_pkt(pkt),
      .push_burst(pkt_burst), .pop(wr_pop), .head_pkt(wr_head),
      .head_burst(wr_head_burst), .not_empty(wr_not_empty), .q_wait(wr_wait));

   erx_queue #(.queue_depth(queue_depth)) rd_q (
      .rx_lclk, .erx_io_reset, .push(rd_push), .push_pkt(pkt),
      .push_burst(pkt_burst), .pop(rd_pop), .head_pkt(rd_head),
      .head_burst(rd_head_burst), .not_empty(rd_not_empty), .q_wait(rd_wait));

   erx_arbiter u_arbiter (
      .rx_lclk, .erx_io_reset,
      .wr_pkt(wr_head), .wr_burst(wr_head_burst), .wr_not_empty,
      .rd_pkt(rd_head), .rd_burst(rd_head_burst), .rd_not_empty,
      .mesh_wait, .wr_pop, .rd_pop, .mesh_access, .mesh_packet, .mesh_burst);

endmodule

`default_nettype wire

/* erx_tb.sv */
//##########################################################################
// receive subsystem testbench
// xorshift packet stimulus, per-class reference queues,
// concurrent checks on mesh output, wait levels and alternation
//##########################################################################

`timescale 1ns/1ps
`default_nettype none

module erx_tb;

   typedef struct packed {
      logic                   burst;
      erx_pkg::emesh_packet_t pkt;
   } exp_t;

   localparam int queue_depth = 8;
   localparam int n_pkts      = 31;                  // 4 single, 3 burst, 16 mixed, 8 stalled
   localparam int max_cycles  = 40 * n_pkts + 200;

   logic                   rx_lclk      = 1'b0;
   logic                   erx_io_reset = 1'b1;
   logic [15:0]            rx_word      = '0;
   logic                   rx_frame     = 1'b0;
   logic                   mesh_wait    = 1'b0;
   logic                   mesh_access, mesh_burst, wr_wait, rd_wait;
   erx_pkg::emesh_packet_t mesh_packet;

   exp_t              exp_wr[$], exp_rd[$];          // expected packets per class
   exp_t              wr_head, rd_head;              // queue heads for the checks
   int                wr_n = 0, rd_n = 0;
   logic [31:0]       rng = 32'h12ec_8c27;
   logic              started = 1'b0;                // first frame sent
   logic              bp_on = 1'b0;                  // stall phase with queues empty at start
   logic              wr_tail = 1'b0;                // last word of a write on the link
   logic [1:0]        wr_dly = '0;                   // link to queue latency
   int                bp_wr_cnt = 0;                 // writes landed during stall
   int                cycles = 0;
   erx_pkg::arb_sel_e next_cls;                      // class due on a tie

   erx_top #(.queue_depth(queue_depth)) dut (
      .rx_lclk, .erx_io_reset, .rx_word, .rx_frame, .mesh_wait,
      .mesh_access, .mesh_packet, .mesh_burst, .wr_wait, .rd_wait);

   always #20 rx_lclk = ~rx_lclk;

   task abort_run;
      $display("Testbench failed");
      $fatal(1);
   endtask

   function logic [31:0] rand32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // link word order with word k in bits 16k+15..16k
   function automatic logic [111:0] encode(input erx_pkg::emesh_packet_t p, input logic [7:0] pad);
      return {p.srcaddr[7:0], p.srcaddr[15:8], p.srcaddr[23:16], p.srcaddr[31:24],
              p.data[7:0], p.data[15:8], p.data[23:16], p.data[31:24],
              p.dstaddr[3:0], p.datamode, p.write, p.access, p.dstaddr[11:4],
              p.dstaddr[19:12], p.dstaddr[27:20], p.ctrlmode, p.dstaddr[31:28], pad};
   endfunction

   function void refresh_heads();
      wr_n    = exp_wr.size();
      rd_n    = exp_rd.size();
      wr_head = (wr_n != 0) ? exp_wr[0] : '0;
      rd_head = (rd_n != 0) ? exp_rd[0] : '0;
   endfunction

   //##########################################################################
   // stimulus
   //##########################################################################
   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge rx_lclk);
         rx_frame = 1'b0;
         rx_word  = 16'(rand32());   // junk between frames
         wr_tail  = 1'b0;
      end
   endtask

   // words first..6 of p with frame held high
   task automatic send_words(input erx_pkg::emesh_packet_t p, input int first, input logic burst);
      logic [111:0] s;
      s = encode(p, 8'(rand32()));
      if (p.write)
         exp_wr.push_back({burst, p});
      else
         exp_rd.push_back({burst, p});
      refresh_heads();
      for (int k = first; k < 7; k++)
      begin
         @(negedge rx_lclk);
         rx_frame = 1'b1;
         rx_word  = s[16*k +: 16];
         wr_tail  = p.write && (k == 6);
         started  = 1'b1;
      end
   endtask

   task automatic send_single(input logic wr);
      logic [127:0] r;
      erx_pkg::emesh_packet_t p;
      r = {rand32(), rand32(), rand32(), rand32()};
      p = r[103:0];
      p.write = wr;
      send_words(p, 0, 1'b0);
      idle(1);
   endtask

   // 7 + 4 + 4 words reusing header words 0..2
   task automatic send_burst;
      logic [127:0] r;
      erx_pkg::emesh_packet_t p;
      r = {rand32(), rand32(), rand32(), rand32()};
      p = r[103:0];
      send_words(p, 0, 1'b0);
      repeat (2)
      begin
         p.data    = rand32();
         p.srcaddr = rand32();
         send_words(p, 3, 1'b1);
      end
      idle(1);
   endtask

   task automatic send_mixed(input int n_each);
      int   nw;
      int   nr;
      logic wr;
      nw = 0;
      nr = 0;
      repeat (2 * n_each)
      begin
         wr = (rand32() & 32'h1) != 0;
         if (nw == n_each)
            wr = 1'b0;                 // class full for this batch
         else if (nr == n_each)
            wr = 1'b1;
         if (wr)
            nw++;
         else
            nr++;
         send_single(wr);
      end
   endtask

   task wait_drained;
      while (wr_n != 0 || rd_n != 0)
         @(posedge rx_lclk);
      @(negedge rx_lclk);
   endtask

   //##########################################################################
   // reference model and checks
   //##########################################################################
   always @(posedge rx_lclk)
   begin
      wr_dly <= {wr_dly[0], wr_tail};
      if (!bp_on)
         bp_wr_cnt <= 0;
      else if (wr_dly[1])
         bp_wr_cnt <= bp_wr_cnt + 1;   // lines up with the queue count
      if (erx_io_reset)
         next_cls <= erx_pkg::sel_wr;
      else if (mesh_access)
      begin
         next_cls <= mesh_packet.write ? erx_pkg::sel_rd : erx_pkg::sel_wr;
         if (mesh_packet.write && wr_n != 0)
            void'(exp_wr.pop_front());
         else if (!mesh_packet.write && rd_n != 0)
            void'(exp_rd.pop_front());
         refresh_heads();
      end
   end

   always @(posedge rx_lclk)
   begin
      cycles++;
      if (cycles > max_cycles)
      begin
         $display("timeout after %0d cycles with packets still outstanding", cycles);
         abort_run();
      end
   end

   a_quiet : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      !started |-> !(mesh_access || wr_wait || rd_wait))
      else
      begin
         $display("ERR mesh_access=%h wr_wait=%h rd_wait=%h before traffic",
                  $sampled(mesh_access), $sampled(wr_wait), $sampled(rd_wait));
         abort_run();
      end

   // packet and burst flag against the head of its class with no extras
   a_packet : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      mesh_access |-> ({1'b1, mesh_burst, mesh_packet} == (mesh_packet.write ?
         {wr_n != 0, wr_head} : {rd_n != 0, rd_head})))
      else
      begin
         $display("ERR mesh_burst,mesh_packet=%h expected %h",
                  {$sampled(mesh_burst), $sampled(mesh_packet)},
                  $sampled(mesh_packet.write) ? $sampled(wr_head) : $sampled(rd_head));
         abort_run();
      end

   a_stall : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      mesh_wait |=> !mesh_access)
      else
      begin
         $display("mesh_access came out while mesh_wait was high");
         abort_run();
      end

   a_wr_wait : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      bp_on |-> (wr_wait == (bp_wr_cnt >= queue_depth - 2)))
      else
      begin
         $display("ERR wr_wait=%h expected %h", $sampled(wr_wait),
                  $sampled(bp_wr_cnt) >= queue_depth - 2);
         abort_run();
      end

   // due class wins when both queues wait at the pop
   a_alternate : assert property (@(posedge rx_lclk) disable iff (erx_io_reset)
      (mesh_access && $past(dut.wr_not_empty) && $past(dut.rd_not_empty))
      |-> (mesh_packet.write == (next_cls == erx_pkg::sel_wr)))
      else
      begin
         $display("ERR mesh_packet.write=%h expected %h", $sampled(mesh_packet.write),
                  $sampled(next_cls) == erx_pkg::sel_wr);
         abort_run();
      end

   //##########################################################################
   // test sequence
   //##########################################################################
   initial
   begin
      repeat (8) @(posedge rx_lclk);
      @(negedge rx_lclk);
      erx_io_reset = 1'b0;
      idle(4);                                  // quiet window after reset
      send_single(1'b1);
      send_single(1'b0);
      send_single(1'b1);
      send_single(1'b0);
      send_burst();
      repeat (2)
      begin
         wait_drained();
         mesh_wait = 1'b1;                      // let both queues fill
         send_mixed(4);
         mesh_wait = 1'b0;
      end
      wait_drained();
      mesh_wait = 1'b1;
      bp_on     = 1'b1;
      for (int i = 0; i < 8; i++)
         send_single(i % 4 != 3);               // 6 writes, 2 reads
      idle(2);
      mesh_wait = 1'b0;
      bp_on     = 1'b0;
      wait_drained();
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
erx_pkg.sv
erx_framer.sv
erx_unpack.sv
erx_queue.sv
erx_arbiter.sv
erx_top.sv
erx_tb.sv
